// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_platformer_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
+incdir+tests
rtl/platformer_pkg.sv
rtl/btn_debounce.sv
rtl/frame_timer.sv
rtl/motion_fsm.sv
rtl/motion_datapath.sv
rtl/apb_debug_regs.sv
rtl/platformer_core.sv
tests/tb_platformer_core.sv

// ==== rtl/apb_debug_regs.sv ====
`timescale 1ns/1ps

module apb_debug_regs (
    input  logic                           sys_clk,
    input  logic                           sys_rst_n,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [7:0]                     paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  platformer_pkg::btn_set_t       press,
    input  platformer_pkg::char_pos_t      pos,
    input  platformer_pkg::motion_status_t status,
    output logic                           timer_en,
    output platformer_pkg::phys_cfg_t      cfg,
    output logic                           teleport,
    output platformer_pkg::char_pos_t      teleport_pos
);

    import platformer_pkg::*;

    apb_wdata_u wdata;
    logic       wr_en;
    logic       rd_en;
    logic       cnt_clr;
    logic [7:0] cnt_left;
    logic [7:0] cnt_right;
    logic [7:0] cnt_jump;

    // Every access completes in its first access cycle
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_en   = psel & penable & pwrite;
    assign rd_en   = psel & penable & ~pwrite;
    assign wdata   = pwdata;
    assign cnt_clr = wr_en && (paddr == REG_CTRL) && pwdata[1];

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            timer_en <= 1'b1;
            cfg      <= '{gravity: RST_GRAVITY, jump_speed: RST_JUMP_SPEED};
            teleport <= 1'b0;
        end else begin
            teleport <= wr_en && (paddr == REG_POS);
            if (wr_en) begin
                case (paddr)
                    REG_CTRL: timer_en <= pwdata[0];
                    REG_PHYS: cfg      <= wdata.phys_view.cfg;
                    default:  ;
                endcase
            end
        end
    end

    // Target position, consumed alongside the teleport strobe
    always_ff @(posedge sys_clk) begin
        if (wr_en && (paddr == REG_POS)) begin
            teleport_pos <= wdata.pos_view.pos;
        end
    end

    // Wrapping press counters, clear wins over a press
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_left  <= '0;
            cnt_right <= '0;
            cnt_jump  <= '0;
        end else if (cnt_clr) begin
            cnt_left  <= '0;
            cnt_right <= '0;
            cnt_jump  <= '0;
        end else begin
            cnt_left  <= cnt_left + 8'(press.left);
            cnt_right <= cnt_right + 8'(press.right);
            cnt_jump  <= cnt_jump + 8'(press.jump);
        end
    end

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            case (paddr)
                REG_CTRL:   prdata = {31'd0, timer_en};
                REG_POS:    prdata = {12'd0, pos};
                REG_PHYS:   prdata = {20'd0, cfg};
                REG_STATUS: prdata = {16'd0, status.vy, 5'd0, status.on_ground, status.state};
                REG_PRESS:  prdata = {8'd0, cnt_jump, cnt_right, cnt_left};
                default:    prdata = '0;
            endcase
        end
    end

    a_penable_psel: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        penable |-> psel);

endmodule

// ==== rtl/btn_debounce.sv ====
`timescale 1ns/1ps

module btn_debounce #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic raw,
    output logic level,
    output logic press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    logic             level_q;

    // Count consecutive samples that disagree with the stored level
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt   <= '0;
            level <= 1'b0;
        end else if (raw == level) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            cnt   <= '0;
            level <= raw;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Press pulse lands one cycle after the level rises
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            level_q <= 1'b0;
            press   <= 1'b0;
        end else begin
            level_q <= level;
            press   <= level & ~level_q;
        end
    end

    a_press_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        press |=> !press);

endmodule

// ==== rtl/frame_timer.sv ====
`timescale 1ns/1ps

module frame_timer #(
    parameter int TICK_CYCLES = 32
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic en,
    output logic tick
);

    localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [CNT_W-1:0] cnt;

    // Disabled timer parks at zero
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt <= '0;
        end else if (!en || tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tick = en && (cnt == CNT_W'(TICK_CYCLES - 1));

    a_tick_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tick |=> !tick);

endmodule

// ==== rtl/motion_datapath.sv ====
`timescale 1ns/1ps

module motion_datapath #(
    parameter int GROUND_Y = 50,
    parameter int X_MAX    = 639
) (
    input  logic                          sys_clk,
    input  logic                          sys_rst_n,
    input  logic                          tick,
    input  platformer_pkg::motion_state_e state,
    input  logic                          jump_req,
    input  platformer_pkg::btn_set_t      held,
    input  platformer_pkg::phys_cfg_t     cfg,
    input  logic                          teleport,
    input  platformer_pkg::char_pos_t     teleport_pos,
    output platformer_pkg::char_pos_t     pos,
    output logic signed [7:0]             vy,
    output logic                          landed,
    output logic                          apex
);

    import platformer_pkg::*;

    localparam logic [9:0] X_LIM = 10'(X_MAX);
    localparam logic [9:0] Y_GND = 10'(GROUND_Y);

    logic               in_air;
    logic [9:0]         x_next;
    logic signed [11:0] y_sum;
    logic [9:0]         y_air;
    logic signed [8:0]  vy_sub;
    logic signed [7:0]  vy_fall;

    assign in_air = (state == ST_RISE) || (state == ST_FALL);

    // Opposite directions cancel, edges saturate
    always_comb begin
        x_next = pos.x;
        if (held.right && !held.left && pos.x < X_LIM) begin
            x_next = pos.x + 1'b1;
        end else if (held.left && !held.right && pos.x != '0) begin
            x_next = pos.x - 1'b1;
        end
    end

    assign y_sum = $signed({2'b00, pos.y}) + $signed({{4{vy[7]}}, vy});
    assign y_air = (y_sum > 12'sd1023) ? 10'h3ff : y_sum[9:0];

    // Gravity with a terminal velocity of -128
    assign vy_sub  = $signed({vy[7], vy}) - $signed({5'd0, cfg.gravity});
    assign vy_fall = (vy_sub < -9'sd128) ? 8'sh80 : vy_sub[7:0];

    assign landed = in_air && (y_sum <= GROUND_Y);
    assign apex   = in_air && !landed && (vy_fall <= 0);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pos.x <= '0;
            pos.y <= Y_GND;
            vy    <= '0;
        end else if (teleport) begin
            // Target clipped into the playfield
            pos.x <= (teleport_pos.x > X_LIM) ? X_LIM : teleport_pos.x;
            pos.y <= (teleport_pos.y < Y_GND) ? Y_GND : teleport_pos.y;
            vy    <= '0;
        end else if (tick) begin
            pos.x <= x_next;
            if (in_air) begin
                if (landed) begin
                    pos.y <= Y_GND;
                    vy    <= '0;
                end else begin
                    pos.y <= y_air;
                    vy    <= vy_fall;
                end
            end else if (jump_req) begin
                vy <= $signed(cfg.jump_speed);
            end
        end
    end

    a_above_ground: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        pos.y >= Y_GND);

endmodule

// ==== rtl/motion_fsm.sv ====
`timescale 1ns/1ps

module motion_fsm (
    input  logic                          sys_clk,
    input  logic                          sys_rst_n,
    input  logic                          tick,
    input  logic                          jump_press,
    input  logic                          landed,
    input  logic                          apex,
    input  logic                          teleport,
    output platformer_pkg::motion_state_e state,
    output logic                          jump_req
);

    import platformer_pkg::*;

    motion_state_e state_next;

    always_comb begin
        state_next = state;
        if (teleport) begin
            state_next = ST_FALL;
        end else if (tick) begin
            case (state)
                ST_GROUND: if (jump_req) state_next = ST_RISE;
                ST_RISE: begin
                    if (landed) begin
                        state_next = ST_GROUND;
                    end else if (apex) begin
                        state_next = ST_FALL;
                    end
                end
                ST_FALL: if (landed) state_next = ST_GROUND;
                default: state_next = ST_GROUND;
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= ST_GROUND;
        end else begin
            state <= state_next;
        end
    end

    // Request held until the next tick; a press on the tick cycle itself is dropped
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_req <= 1'b0;
        end else if (teleport || tick) begin
            jump_req <= 1'b0;
        end else if (jump_press) begin
            jump_req <= 1'b1;
        end
    end

    a_state_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        state inside {ST_GROUND, ST_RISE, ST_FALL});

endmodule

// ==== rtl/platformer_core.sv ====
`timescale 1ns/1ps

module platformer_core #(
    parameter int DEBOUNCE_CYCLES = 16,
    parameter int TICK_CYCLES     = 32,
    parameter int GROUND_Y        = 50,
    parameter int X_MAX           = 639
) (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  platformer_pkg::btn_set_t btn_raw,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [7:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr
);

    import platformer_pkg::*;

    btn_set_t          btn_level;
    btn_set_t          btn_press;
    logic              tick;
    logic              timer_en;
    logic              jump_req;
    logic              landed;
    logic              apex;
    logic              teleport;
    motion_state_e     state;
    char_pos_t         pos;
    char_pos_t         teleport_pos;
    logic signed [7:0] vy;
    phys_cfg_t         cfg;
    motion_status_t    status;

    btn_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_left (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .raw(btn_raw.left),
        .level(btn_level.left), .press(btn_press.left)
    );

    btn_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_right (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .raw(btn_raw.right),
        .level(btn_level.right), .press(btn_press.right)
    );

    btn_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_jump (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .raw(btn_raw.jump),
        .level(btn_level.jump), .press(btn_press.jump)
    );

    frame_timer #(.TICK_CYCLES(TICK_CYCLES)) i_frame_timer (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .en(timer_en), .tick(tick)
    );

    motion_fsm i_motion_fsm (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .tick(tick),
        .jump_press(btn_press.jump), .landed(landed), .apex(apex),
        .teleport(teleport), .state(state), .jump_req(jump_req)
    );

    motion_datapath #(.GROUND_Y(GROUND_Y), .X_MAX(X_MAX)) i_motion_datapath (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .tick(tick), .state(state),
        .jump_req(jump_req), .held(btn_level), .cfg(cfg), .teleport(teleport),
        .teleport_pos(teleport_pos), .pos(pos), .vy(vy), .landed(landed), .apex(apex)
    );

    // Status word for the debug readout
    assign status = '{state: state, on_ground: (state == ST_GROUND), vy: vy};

    apb_debug_regs i_apb_debug_regs (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .press(btn_press), .pos(pos), .status(status), .timer_en(timer_en),
        .cfg(cfg), .teleport(teleport), .teleport_pos(teleport_pos)
    );

endmodule

// ==== rtl/platformer_pkg.sv ====
package platformer_pkg;

    // Character phase
    typedef enum logic [1:0] {
        ST_GROUND = 2'd0,
        ST_RISE   = 2'd1,
        ST_FALL   = 2'd2
    } motion_state_e;

    // Raw buttons, debounced levels and press pulses
    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } btn_set_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } char_pos_t;

    typedef struct packed {
        logic [3:0] gravity;
        logic [7:0] jump_speed;
    } phys_cfg_t;

    typedef struct packed {
        motion_state_e     state;
        logic              on_ground;
        logic signed [7:0] vy;
    } motion_status_t;

    // APB write word, view picked by the register address
    typedef union packed {
        struct packed {
            logic [11:0] rsvd;
            char_pos_t   pos;
        } pos_view;
        struct packed {
            logic [19:0] rsvd;
            phys_cfg_t   cfg;
        } phys_view;
    } apb_wdata_u;

    // Register map
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_POS    = 8'h04;
    localparam logic [7:0] REG_PHYS   = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;
    localparam logic [7:0] REG_PRESS  = 8'h10;

    localparam logic [3:0] RST_GRAVITY    = 4'd1;
    localparam logic [7:0] RST_JUMP_SPEED = 8'd12;

endpackage

// ==== tests/platformer_model.svh ====
`ifndef PLATFORMER_MODEL_SVH
`define PLATFORMER_MODEL_SVH

// Reference state, advanced once per rising clock edge out of reset
logic [2:0]    m_lvl;
logic [2:0]    m_lvl_q;
logic [2:0]    m_press;
int            m_dcnt [3];
int            m_cnt [3];
int            m_tcnt;
logic          m_ten;
logic [3:0]    m_grav;
logic [7:0]    m_jspd;
logic          m_tele;
int            m_tx;
int            m_ty;
motion_state_e m_state;
logic          m_jreq;
int            m_x;
int            m_y;
int            m_vy;

task automatic reset_model();
    int b;
    for (b = 0; b < 3; b++) begin
        m_dcnt[b] = 0;
        m_cnt[b]  = 0;
    end
    m_lvl   = '0;
    m_lvl_q = '0;
    m_press = '0;
    m_tcnt  = 0;
    m_ten   = 1'b1;
    m_grav  = 4'd1;
    m_jspd  = 8'd12;
    m_tele  = 1'b0;
    m_tx    = 0;
    m_ty    = GND;
    m_state = ST_GROUND;
    m_jreq  = 1'b0;
    m_x     = 0;
    m_y     = GND;
    m_vy    = 0;
endtask

task automatic step_model();
    int         b;
    logic [2:0] raw;
    logic       wr;
    logic       tick;
    logic       in_air;
    logic       landed;
    logic       apex;
    int         y_next;
    int         vy_next;
    raw     = btn_raw;
    wr      = psel && penable && pwrite;
    tick    = m_ten && (m_tcnt == TICK - 1);
    in_air  = (m_state != ST_GROUND);
    y_next  = m_y + m_vy;
    vy_next = m_vy - int'(m_grav);
    landed  = in_air && (y_next <= GND);
    apex    = in_air && !landed && (vy_next <= 0);
    // Counters see this cycle's press pulses, a clear wins
    for (b = 0; b < 3; b++) begin
        if (wr && paddr == REG_CTRL && pwdata[1]) begin
            m_cnt[b] = 0;
        end else begin
            m_cnt[b] = (m_cnt[b] + int'(m_press[b])) % 256;
        end
    end
    if (m_tele) begin
        m_x  = m_tx;
        m_y  = m_ty;
        m_vy = 0;
    end else if (tick) begin
        if (m_lvl[1] && !m_lvl[2] && m_x < XMAX) begin
            m_x = m_x + 1;
        end else if (m_lvl[2] && !m_lvl[1] && m_x > 0) begin
            m_x = m_x - 1;
        end
        if (in_air && landed) begin
            m_y  = GND;
            m_vy = 0;
        end else if (in_air) begin
            m_y  = y_next;
            m_vy = vy_next;
        end else if (m_jreq) begin
            m_vy = int'(m_jspd);
        end
    end
    // Phase change uses the request from before this edge
    if (m_tele) begin
        m_state = ST_FALL;
    end else if (tick && m_state == ST_GROUND && m_jreq) begin
        m_state = ST_RISE;
    end else if (tick && in_air && landed) begin
        m_state = ST_GROUND;
    end else if (tick && m_state == ST_RISE && apex) begin
        m_state = ST_FALL;
    end
    if (m_tele || tick) begin
        m_jreq = 1'b0;
    end else if (m_press[0]) begin
        m_jreq = 1'b1;
    end
    for (b = 0; b < 3; b++) begin
        m_press[b] = m_lvl[b] && !m_lvl_q[b];
        m_lvl_q[b] = m_lvl[b];
        if (raw[b] == m_lvl[b]) begin
            m_dcnt[b] = 0;
        end else if (m_dcnt[b] == DB - 1) begin
            m_dcnt[b] = 0;
            m_lvl[b]  = raw[b];
        end else begin
            m_dcnt[b] = m_dcnt[b] + 1;
        end
    end
    m_tcnt = (!m_ten || tick) ? 0 : m_tcnt + 1;
    m_tele = wr && paddr == REG_POS;
    if (m_tele) begin
        m_tx = int'(pwdata[19:10]);
        m_ty = int'(pwdata[9:0]);
    end
    if (wr && paddr == REG_CTRL) begin
        m_ten = pwdata[0];
    end
    if (wr && paddr == REG_PHYS) begin
        m_grav = pwdata[11:8];
        m_jspd = pwdata[7:0];
    end
endtask

// Register map as seen from the bus
function automatic logic [31:0] expected_read(input logic [7:0] addr);
    case (addr)
        REG_CTRL:   return {31'd0, m_ten};
        REG_POS:    return {12'd0, 10'(m_x), 10'(m_y)};
        REG_PHYS:   return {20'd0, m_grav, m_jspd};
        REG_STATUS: return {16'd0, 8'(m_vy), 5'd0, m_state == ST_GROUND, m_state};
        REG_PRESS:  return {8'd0, 8'(m_cnt[0]), 8'(m_cnt[1]), 8'(m_cnt[2])};
        default:    return 32'd0;
    endcase
endfunction

`endif

// ==== tests/tb_platformer_core.sv ====
`timescale 1ns/1ps

module tb_platformer_core;

    import platformer_pkg::*;

    localparam int DB   = 3;
    localparam int TICK = 8;
    localparam int GND  = 50;
    localparam int XMAX = 60;

    localparam int MAX_HOLD  = 40;
    localparam int N_GLITCH  = 12;
    localparam int N_COUNT   = 30;
    localparam int N_WALK    = 40;
    localparam int N_JUMPS   = 8;
    localparam int N_TELE    = 5;
    localparam int N_FROZEN  = 16;
    // Worst case per hold and per airborne stretch
    localparam int HOLD_CYCLES = MAX_HOLD + 8;
    localparam int AIR_CYCLES  = 1200;
    localparam int CYCLE_LIMIT = N_GLITCH * 8
                               + (N_COUNT + N_WALK + N_FROZEN + 3) * HOLD_CYCLES
                               + (N_JUMPS + N_TELE) * AIR_CYCLES + 200;

    logic        sys_clk = 1'b0;
    logic        sys_rst_n;
    btn_set_t    btn_raw;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] seed = 32'h2e9e;
    int          cycle_count = 0;
    logic [7:0]  read_addrs [5] = '{REG_CTRL, REG_POS, REG_PHYS, REG_STATUS, REG_PRESS};

    `include "platformer_model.svh"

    platformer_core #(
        .DEBOUNCE_CYCLES(DB),
        .TICK_CYCLES(TICK),
        .GROUND_Y(GND),
        .X_MAX(XMAX)
    ) i_platformer_core (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .btn_raw(btn_raw),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        if (sys_rst_n) begin
            step_model();
        end
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // LCG, result drawn from the upper bits
    function automatic int rand_range(input int lo, input int hi);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return lo + int'((seed >> 8) % 32'(hi - lo + 1));
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Bus tasks start and end on a falling edge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge sys_clk);
        penable = 1'b1;
        @(negedge sys_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read_check(input logic [7:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge sys_clk);
        penable = 1'b1;
        #1;
        data = prdata;
        check_value("pready", 32'(pready), 32'd1);
        check_value("pslverr", 32'(pslverr), 32'd0);
        check_value($sformatf("prdata@%02h", addr), prdata, expected_read(addr));
        @(negedge sys_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // POS every 4 cycles so each tick's x gets compared
    task automatic hold_buttons(input logic [2:0] value, input int cycles);
        int          i;
        logic [31:0] d;
        btn_raw = value;
        for (i = 0; i < cycles; i += 4) begin
            apb_read_check(REG_POS, d);
            apb_read_check(read_addrs[rand_range(0, 4)], d);
        end
    endtask

    task automatic wait_landing();
        hold_buttons(3'b000, 4);
        while (m_state != ST_GROUND) begin
            hold_buttons(3'b000, 8);
        end
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] saved;
        int          i;
        int          tx;
        int          ty;
        sys_rst_n = 1'b0;
        btn_raw   = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        reset_model();
        repeat (2) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);

        apb_read_check(REG_POS, d);
        check_value("pos after reset", d, {12'd0, 10'd0, 10'd50});
        apb_read_check(REG_STATUS, d);
        check_value("status after reset", d, 32'h0000_0004);
        apb_read_check(REG_PRESS, d);
        check_value("press after reset", d, 32'd0);

        // Short glitches never reach the debounced level
        for (i = 0; i < N_GLITCH; i++) begin
            btn_raw = 3'(rand_range(1, 7));
            repeat (rand_range(1, DB - 1)) @(negedge sys_clk);
            btn_raw = '0;
            repeat (4) @(negedge sys_clk);
        end
        apb_read_check(REG_PRESS, d);
        check_value("press after glitches", d, 32'd0);
        apb_read_check(REG_POS, d);
        check_value("pos after glitches", d, {12'd0, 10'd0, 10'd50});

        for (i = 0; i < N_COUNT; i++) begin
            hold_buttons(3'(rand_range(0, 7)), rand_range(1, MAX_HOLD));
        end
        hold_buttons(3'b000, 16);
        apb_write(REG_CTRL, 32'h3);
        apb_read_check(REG_PRESS, d);
        check_value("press after clear", d, 32'd0);

        // Walk near both edges of the playfield
        apb_write(REG_POS, {12'd0, 10'd57, 10'd50});
        for (i = 0; i < N_WALK; i++) begin
            if (i == N_WALK / 2) begin
                apb_write(REG_POS, {12'd0, 10'd3, 10'd50});
            end
            hold_buttons(3'(rand_range(0, 3) << 1), rand_range(1, MAX_HOLD));
        end

        for (i = 0; i < N_JUMPS; i++) begin
            apb_write(REG_PHYS, {20'd0, 4'(rand_range(1, 15)), 8'(rand_range(1, 40))});
            hold_buttons({2'(rand_range(0, 3)), 1'b1}, rand_range(12, MAX_HOLD));
            wait_landing();
        end

        // Odd passes land the teleport on a tick edge
        for (i = 0; i < N_TELE; i++) begin
            hold_buttons(3'b000, 4);
            if (i % 2 == 1) begin
                while (m_tcnt != TICK - 3) begin
                    @(negedge sys_clk);
                end
            end else begin
                repeat (rand_range(0, 7)) @(negedge sys_clk);
            end
            tx = rand_range(0, XMAX);
            ty = rand_range(GND + 1, 350);
            apb_write(REG_POS, {12'd0, 10'(tx), 10'(ty)});
            if (i % 2 == 1) begin
                check_value("teleport on tick",
                            {30'd0, i_platformer_core.teleport, i_platformer_core.tick},
                            32'd3);
            end
            apb_read_check(REG_STATUS, d);
            check_value("status after teleport", d, {16'd0, 8'd0, 5'd0, 1'b0, ST_FALL});
            apb_read_check(REG_POS, d);
            check_value("pos after teleport", d, {12'd0, 10'(tx), 10'(ty)});
            wait_landing();
            apb_read_check(REG_POS, d);
            check_value("y after landing", 32'(d[9:0]), 32'd50);
        end

        // Timer off freezes motion but not the counters
        apb_write(REG_POS, {12'd0, 10'd10, 10'd50});
        apb_write(REG_CTRL, 32'h0);
        apb_read_check(REG_POS, saved);
        check_value("pos before freeze", saved, {12'd0, 10'd10, 10'd50});
        for (i = 0; i < N_FROZEN; i++) begin
            hold_buttons(3'(rand_range(0, 7)), rand_range(1, MAX_HOLD));
            apb_read_check(REG_POS, d);
            check_value("pos while frozen", d, saved);
        end
        hold_buttons(3'b000, 8);
        apb_write(REG_CTRL, 32'h1);
        hold_buttons(3'b010, MAX_HOLD);
        apb_read_check(REG_POS, d);
        check_value("x moving again", 32'(d[19:10] > 10'd10), 32'd1);

        $display("No errors");
        $finish;
    end

endmodule
